/* rtl/koaPkg.sv */
// Karatsuba-Ofman multiplier shared definitions
// Operand widths and the structs passed between the pipeline blocks

`default_nettype none

package koaPkg;

    //======================================================================
    // Widths
    //======================================================================

    // Full operand width
    localparam int OP_WIDTH = 32;

    // One half of an operand, the leaf width for the outer products
    localparam int HALF_WIDTH = OP_WIDTH / 2;

    // Sum of two halves keeps the carry bit
    localparam int SUM_WIDTH = HALF_WIDTH + 1;

    //======================================================================
    // Pipeline payloads
    //======================================================================

    // Operand pair with its valid strobe
    typedef struct packed {
        logic                valid;
        logic [OP_WIDTH-1:0] a;
        logic [OP_WIDTH-1:0] b;
    } mulReqT;

    // High-by-high and low-by-low products
    typedef struct packed {
        logic                  valid;
        logic [2*HALF_WIDTH-1:0] hiProd;
        logic [2*HALF_WIDTH-1:0] loProd;
    } partialsT;

    // Product of the two half sums, no strobe of its own
    typedef logic [2*SUM_WIDTH-1:0] midProdT;

    // Final result with its valid strobe
    typedef struct packed {
        logic                  valid;
        logic [2*OP_WIDTH-1:0] prod;
    } mulRspT;

endpackage

`default_nettype wire

/* rtl/baseMult.sv */
// Leaf multiplier of the Karatsuba recursion
// Registers the native product of two unsigned operands

`timescale 1ns/1ps
`default_nettype none

module baseMult #(
    parameter int Width = 16
) (
    input  logic               clk_i,
    input  logic               rstN_i,
    input  logic [Width-1:0]   a_i,
    input  logic [Width-1:0]   b_i,
    output logic [2*Width-1:0] prod_o
);

    // Native multiply, full double width
    logic [2*Width-1:0] prodNext;

    // Zero-extend both sides so the product is not truncated
    always_comb begin
        prodNext = {{Width{1'b0}}, a_i} * {{Width{1'b0}}, b_i};
    end

    // One register stage
    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            prod_o <= '0;
        end else begin
            prod_o <= prodNext;
        end
    end

    //======================================================================
    // Checks
    //======================================================================

    // Product stays known once out of reset
    // X here would mean an undriven operand upstream
    assert property (@(posedge clk_i) disable iff (!rstN_i)
        !$isunknown(prod_o))
        else $error("baseMult: product went unknown after reset");

endmodule

`default_nettype wire

/* rtl/koaOuterProducts.sv */
// Outer products of the Karatsuba step
// Splits both operands into halves and forms high-by-high and low-by-low,
// carrying the valid strobe alongside the products

`timescale 1ns/1ps
`default_nettype none

module koaOuterProducts (
    input  logic              clk_i,
    input  logic              rstN_i,
    input  koaPkg::mulReqT    req_i,
    output koaPkg::partialsT  partials_o
);

    // Registered operand halves
    typedef struct packed {
        logic [koaPkg::HALF_WIDTH-1:0] aHi;
        logic [koaPkg::HALF_WIDTH-1:0] aLo;
        logic [koaPkg::HALF_WIDTH-1:0] bHi;
        logic [koaPkg::HALF_WIDTH-1:0] bLo;
    } halvesT;

    halvesT halvesQ;

    // Valid strobe, one flop per pipeline stage
    logic vldStage1Q;
    logic vldStage2Q;

    // Leaf outputs
    logic [2*koaPkg::HALF_WIDTH-1:0] hiProd;
    logic [2*koaPkg::HALF_WIDTH-1:0] loProd;

    //======================================================================
    // Stage 1, split and register
    //======================================================================

    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            halvesQ    <= '0;
            vldStage1Q <= 1'b0;
        end else begin
            // Upper half of each operand
            halvesQ.aHi <= req_i.a[koaPkg::OP_WIDTH-1 -: koaPkg::HALF_WIDTH];
            halvesQ.bHi <= req_i.b[koaPkg::OP_WIDTH-1 -: koaPkg::HALF_WIDTH];
            // Lower half
            halvesQ.aLo <= req_i.a[koaPkg::HALF_WIDTH-1:0];
            halvesQ.bLo <= req_i.b[koaPkg::HALF_WIDTH-1:0];
            vldStage1Q  <= req_i.valid;
        end
    end

    //======================================================================
    // Stage 2, leaf multipliers
    //======================================================================

    // High halves
    baseMult #(
        .Width(koaPkg::HALF_WIDTH)
    ) hiMult_i (
        .clk_i (clk_i),
        .rstN_i(rstN_i),
        .a_i   (halvesQ.aHi),
        .b_i   (halvesQ.bHi),
        .prod_o(hiProd)
    );

    // Low halves
    baseMult #(
        .Width(koaPkg::HALF_WIDTH)
    ) loMult_i (
        .clk_i (clk_i),
        .rstN_i(rstN_i),
        .a_i   (halvesQ.aLo),
        .b_i   (halvesQ.bLo),
        .prod_o(loProd)
    );

    // Valid follows the leaf register
    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            vldStage2Q <= 1'b0;
        end else begin
            vldStage2Q <= vldStage1Q;
        end
    end

    // Pack for the combine block
    assign partials_o.valid  = vldStage2Q;
    assign partials_o.hiProd = hiProd;
    assign partials_o.loProd = loProd;

endmodule

`default_nettype wire

/* rtl/koaMiddleProduct.sv */
// Middle product of the Karatsuba step
// Pre-adds the halves of each operand and multiplies the two 17-bit sums

`timescale 1ns/1ps
`default_nettype none

module koaMiddleProduct (
    input  logic            clk_i,
    input  logic            rstN_i,
    input  koaPkg::mulReqT  req_i,
    output koaPkg::midProdT midProd_o
);

    // Half sums, carry kept in the top bit
    logic [koaPkg::SUM_WIDTH-1:0] sumA;
    logic [koaPkg::SUM_WIDTH-1:0] sumB;

    // Registered sums feeding the leaf
    logic [koaPkg::SUM_WIDTH-1:0] sumAQ;
    logic [koaPkg::SUM_WIDTH-1:0] sumBQ;

    //======================================================================
    // Stage 1, pre-add
    //======================================================================

    // Widen each half by one bit before adding
    always_comb begin
        sumA = {1'b0, req_i.a[koaPkg::OP_WIDTH-1 -: koaPkg::HALF_WIDTH]}
             + {1'b0, req_i.a[koaPkg::HALF_WIDTH-1:0]};
        sumB = {1'b0, req_i.b[koaPkg::OP_WIDTH-1 -: koaPkg::HALF_WIDTH]}
             + {1'b0, req_i.b[koaPkg::HALF_WIDTH-1:0]};
    end

    // Same depth as the outer halves register
    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            sumAQ <= '0;
            sumBQ <= '0;
        end else begin
            sumAQ <= sumA;
            sumBQ <= sumB;
        end
    end

    //======================================================================
    // Stage 2, leaf multiply
    //======================================================================

    // 17 by 17, 34-bit result
    baseMult #(
        .Width(koaPkg::SUM_WIDTH)
    ) midMult_i (
        .clk_i (clk_i),
        .rstN_i(rstN_i),
        .a_i   (sumAQ),
        .b_i   (sumBQ),
        .prod_o(midProd_o)
    );

endmodule

`default_nettype wire

/* rtl/koaCombine.sv */
// Karatsuba combine step
// Removes the outer products from the middle product, aligns the three
// terms and registers the full 64-bit result with its valid strobe

`timescale 1ns/1ps
`default_nettype none

module koaCombine (
    input  logic             clk_i,
    input  logic             rstN_i,
    input  koaPkg::partialsT partials_i,
    input  koaPkg::midProdT  midProd_i,
    output koaPkg::mulRspT   rsp_o
);

    localparam int MidWidth = 2 * koaPkg::SUM_WIDTH;
    localparam int OutWidth = 2 * koaPkg::OP_WIDTH;

    // Outer products widened to the middle width
    logic [MidWidth-1:0] outerSum;

    // aHi*bLo + aLo*bHi
    logic [MidWidth-1:0] midTerm;

    // Middle term placed at bit 16 of the result
    logic [OutWidth-1:0] midAligned;

    // Unregistered result
    logic [OutWidth-1:0] prodNext;

    //======================================================================
    // Middle term
    //======================================================================

    always_comb begin
        outerSum = {{(MidWidth-2*koaPkg::HALF_WIDTH){1'b0}}, partials_i.hiProd}
                 + {{(MidWidth-2*koaPkg::HALF_WIDTH){1'b0}}, partials_i.loProd};
        // Never underflows for a real operand pair
        midTerm  = midProd_i - outerSum;
    end

    //======================================================================
    // Alignment and final add
    //======================================================================

    always_comb begin
        // Zero-extend, then shift up by one half
        midAligned = {{(OutWidth-MidWidth){1'b0}}, midTerm} << koaPkg::HALF_WIDTH;
        // High product sits at bit 32, low product at bit 0
        // so the two simply concatenate
        prodNext   = {partials_i.hiProd, partials_i.loProd} + midAligned;
    end

    // Output register, third pipeline stage
    always_ff @(posedge clk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            rsp_o <= '0;
        end else begin
            rsp_o.valid <= partials_i.valid;
            rsp_o.prod  <= prodNext;
        end
    end

    //======================================================================
    // Checks
    //======================================================================

    // Middle product and outer products must come from the same pair
    // A slip between the two product blocks shows up here first
    assert property (@(posedge clk_i) disable iff (!rstN_i)
        partials_i.valid |-> (midProd_i >= outerSum))
        else $error("koaCombine: middle product below sum of outer products");

endmodule

`default_nettype wire

/* rtl/karatsubaMultTop.sv */
// Pipelined 32x32 unsigned Karatsuba-Ofman multiplier
// One operand pair per cycle in, result three cycles later

`timescale 1ns/1ps
`default_nettype none

module karatsubaMultTop (
    input  logic            clk_i,
    input  logic            rstN_i,
    input  koaPkg::mulReqT  req_i,
    output koaPkg::mulRspT  rsp_o
);

    // Outer products and their valid strobe
    koaPkg::partialsT partials;

    // Middle product, aligned with partials by equal depth
    koaPkg::midProdT  midProd;

    //======================================================================
    // Product blocks, side by side
    //======================================================================

    koaOuterProducts koaOuterProducts_i (
        .clk_i     (clk_i),
        .rstN_i    (rstN_i),
        .req_i     (req_i),
        .partials_o(partials)
    );

    koaMiddleProduct koaMiddleProduct_i (
        .clk_i    (clk_i),
        .rstN_i   (rstN_i),
        .req_i    (req_i),
        .midProd_o(midProd)
    );

    //======================================================================
    // Combine
    //======================================================================

    koaCombine koaCombine_i (
        .clk_i     (clk_i),
        .rstN_i    (rstN_i),
        .partials_i(partials),
        .midProd_i (midProd),
        .rsp_o     (rsp_o)
    );

endmodule

`default_nettype wire

/* dv/tbClockGen.sv */
// Testbench clock and power-on reset
// 100 ns period, reset held low for a set number of rising edges

`timescale 1ns/1ps
`default_nettype none

module tbClockGen #(
    parameter int RstCycles = 16
) (
    output logic clk_o,
    output logic rstN_o
);

    // Half of the 100 ns period
    localparam int HalfPeriod = 50;

    initial begin
        clk_o = 1'b0;
        forever begin
            #(HalfPeriod) clk_o = ~clk_o;
        end
    end

    // Release just after an edge, away from the sampling point
    initial begin
        rstN_o = 1'b0;
        repeat (RstCycles) @(posedge clk_o);
        #1;
        rstN_o = 1'b1;
    end

endmodule

`default_nettype wire

/* dv/karatsubaMultTb.sv */
// Testbench for the pipelined 32x32 Karatsuba multiplier
// Directed pairs from a pattern file, LFSR random streams, latency
// and mid-stream reset checks against a plain reference product

`timescale 1ns/1ps
`default_nettype none

module karatsubaMultTb;

    localparam int Latency     = 3;
    localparam int WaitLimit   = 20;
    localparam int RunLimit    = 3000;
    localparam int RandomCount = 200;
    localparam int SparseCount = 60;

    logic clk;
    logic porRstN;
    logic tbRstN;
    logic dutRstN;

    koaPkg::mulReqT req;
    koaPkg::mulRspT rsp;

    // Expected responses, each with the cycle it is due on
    koaPkg::mulRspT expQ[$];
    int             dueQ[$];

    int          cycleCnt;
    string       testName;
    logic [31:0] lfsrState;

    tbClockGen #(
        .RstCycles(16)
    ) tbClockGen_i (
        .clk_o (clk),
        .rstN_o(porRstN)
    );

    // Power-on reset plus the mid-stream reset of the testbench
    assign dutRstN = porRstN & tbRstN;

    karatsubaMultTop karatsubaMultTop_i (
        .clk_i (clk),
        .rstN_i(dutRstN),
        .req_i (req),
        .rsp_o (rsp)
    );

    //======================================================================
    // Reference model and random source
    //======================================================================

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    // Plain unsigned product, valid set
    function automatic koaPkg::mulRspT refRsp(input logic [31:0] a, input logic [31:0] b);
        koaPkg::mulRspT r;
        r.valid = 1'b1;
        r.prod  = {{koaPkg::OP_WIDTH{1'b0}}, a} * {{koaPkg::OP_WIDTH{1'b0}}, b};
        return r;
    endfunction

    //======================================================================
    // Checks
    //======================================================================

    task automatic failRun(input string msg);
        $display("STATUS: FAIL");
        $fatal(1, "%s", msg);
    endtask

    task automatic checkRsp(input string name, input koaPkg::mulRspT expRsp,
                            input koaPkg::mulRspT actRsp);
        if (actRsp !== expRsp) begin
            $display("Mismatch in %s: expected valid=%0b prod=%h, actual valid=%0b prod=%h",
                     name, expRsp.valid, expRsp.prod, actRsp.valid, actRsp.prod);
            failRun("response differs from the reference product");
        end
    endtask

    task automatic checkValid(input string name, input logic expVld, input logic actVld);
        if (actVld !== expVld) begin
            $display("Mismatch in %s: expected valid=%0b, actual valid=%0b",
                     name, expVld, actVld);
            failRun("response valid strobe on the wrong cycle");
        end
    endtask

    task automatic checkLatency(input string name, input int expLat, input int actLat);
        if (actLat != expLat) begin
            $display("Mismatch in %s: expected latency %0d, actual latency %0d",
                     name, expLat, actLat);
            failRun("result latency is wrong");
        end
    endtask

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
    end

    // Sample on the falling edge, where rsp is stable
    always @(negedge clk) begin
        if (!dutRstN) begin
            checkValid({testName, " in reset"}, 1'b0, rsp.valid);
        end else if (dueQ.size() > 0 && dueQ[0] == cycleCnt) begin
            checkRsp(testName, expQ[0], rsp);
            void'(expQ.pop_front());
            void'(dueQ.pop_front());
        end else begin
            // No result due, strobe must be low
            checkValid(testName, 1'b0, rsp.valid);
        end
    end

    //======================================================================
    // Stimulus
    //======================================================================

    task automatic stepToDrive();
        @(posedge clk);
        #1;
    endtask

    // Sampled on the next edge, result on rsp two edges after that
    task automatic sendPair(input logic [31:0] a, input logic [31:0] b,
                            input koaPkg::mulRspT expRsp);
        stepToDrive();
        req.valid = 1'b1;
        req.a     = a;
        req.b     = b;
        expQ.push_back(expRsp);
        dueQ.push_back(cycleCnt + Latency);
    endtask

    task automatic idleCycle();
        stepToDrive();
        req.valid = 1'b0;
    endtask

    task automatic waitDrain();
        int n;
        n = 0;
        idleCycle();
        while (expQ.size() > 0) begin
            if (n >= WaitLimit) begin
                failRun("expected results never arrived");
            end
            @(posedge clk);
            n++;
        end
    endtask

    task automatic waitResetRelease();
        int n;
        n = 0;
        while (porRstN !== 1'b1) begin
            if (n >= 40) begin
                failRun("power-on reset was never released");
            end
            @(posedge clk);
            n++;
        end
    endtask

    //======================================================================
    // Tests
    //======================================================================

    task automatic runDirected();
        int             fd;
        int             cnt;
        int             n;
        string          line;
        logic [31:0]    a;
        logic [31:0]    b;
        logic [63:0]    prod;
        koaPkg::mulRspT expRsp;
        testName = "directed";
        fd = $fopen("dv/koaPatterns.txt", "r");
        if (fd == 0) begin
            failRun("could not open the pattern file dv/koaPatterns.txt");
        end
        cnt = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Skip comment lines, blank lines fall out of the scan
            if (line.substr(0, 0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h", a, b, prod);
            if (n == 3) begin
                expRsp.valid = 1'b1;
                expRsp.prod  = prod;
                sendPair(a, b, expRsp);
                cnt++;
            end
        end
        $fclose(fd);
        if (cnt == 0) begin
            failRun("pattern file held no operand pairs");
        end
        waitDrain();
    endtask

    task automatic runLatency();
        int startCyc;
        int n;
        testName = "latency";
        sendPair(32'h0001_2345, 32'h0000_0100, refRsp(32'h0001_2345, 32'h0000_0100));
        // Cycle the request is presented in
        startCyc = cycleCnt;
        idleCycle();
        n = 0;
        while (1) begin
            @(negedge clk);
            if (rsp.valid) begin
                break;
            end
            if (n >= WaitLimit) begin
                failRun("isolated request never produced a result");
            end
            n++;
        end
        checkLatency(testName, Latency, cycleCnt - startCyc);
        waitDrain();
    endtask

    task automatic runFullRate();
        logic [31:0] a;
        logic [31:0] b;
        testName = "full-rate";
        for (int i = 0; i < RandomCount; i++) begin
            a = randBits(32);
            b = randBits(32);
            sendPair(a, b, refRsp(a, b));
        end
        waitDrain();
    endtask

    // Up to three idle cycles before each pair
    task automatic runSparse();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] gap;
        testName = "sparse";
        for (int i = 0; i < SparseCount; i++) begin
            gap = randBits(2);
            repeat (gap) idleCycle();
            a = randBits(32);
            b = randBits(32);
            sendPair(a, b, refRsp(a, b));
        end
        waitDrain();
    endtask

    task automatic runResetMid();
        logic [31:0] a;
        logic [31:0] b;
        testName = "mid-reset";
        for (int i = 0; i < 5; i++) begin
            a = randBits(32);
            b = randBits(32);
            sendPair(a, b, refRsp(a, b));
        end
        // Last three pairs still in flight here
        stepToDrive();
        req.valid = 1'b0;
        tbRstN    = 1'b0;
        expQ.delete();
        dueQ.delete();
        repeat (3) stepToDrive();
        tbRstN = 1'b1;
        // Nothing may come out of the flushed pipe
        repeat (5) idleCycle();
        for (int i = 0; i < 8; i++) begin
            a = randBits(32);
            b = randBits(32);
            sendPair(a, b, refRsp(a, b));
        end
        waitDrain();
    endtask

    //======================================================================
    // Main sequence
    //======================================================================

    initial begin
        req       = '0;
        tbRstN    = 1'b1;
        cycleCnt  = 0;
        lfsrState = 32'h2291585d;
        testName  = "power-on";
        waitResetRelease();
        runDirected();
        runLatency();
        runFullRate();
        runSparse();
        runResetMid();
        repeat (3) idleCycle();
        $display("STATUS: PASS");
        $finish;
    end

    // Hang guard for the whole run
    initial begin
        repeat (RunLimit) @(posedge clk);
        failRun("simulation ran past its cycle limit");
    end

endmodule

`default_nettype wire

/* flist.f */
rtl/koaPkg.sv
rtl/baseMult.sv
rtl/koaOuterProducts.sv
rtl/koaMiddleProduct.sv
rtl/koaCombine.sv
rtl/karatsubaMultTop.sv
dv/tbClockGen.sv
dv/karatsubaMultTb.sv

/* Makefile */
# Verilator flow for the pipelined Karatsuba multiplier
# Run from the project root, the testbench opens dv/koaPatterns.txt

VERILATOR ?= verilator
TOP       ?= karatsubaMultTb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
ARGS      ?=

# Timing for the testbench delays, assertions kept in the model
VFLAGS = --timing --assert --top-module $(TOP) -f $(FLIST)

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

# Static checks only
lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(ARGS)

# Compile the testbench and the DUT into one binary
build:
	$(VERILATOR) --binary $(VFLAGS) --Mdir $(OBJ_DIR) $(ARGS)

# A $fatal in the testbench gives a non-zero exit status here
sim: build
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* dv/koaPatterns.txt */
# Directed operand pairs for the 32x32 Karatsuba multiplier
# Columns: operand a, operand b, expected 64-bit product, all hex
00000000 00000000 0000000000000000
00000001 00000001 0000000000000001
ffffffff ffffffff fffffffe00000001
00000000 ffffffff 0000000000000000
ffffffff 00000001 00000000ffffffff
00000001 ffffffff 00000000ffffffff
00010000 00010000 0000000100000000
80000000 80000000 4000000000000000
80000000 00000002 0000000100000000
ffff0000 ffff0000 fffe000100000000
0000ffff 0000ffff 00000000fffe0001
ffff0001 00010001 0001000000000001
80008000 80008000 4000800040000000
ffffffff 00010000 0000ffffffff0000
12345678 00000010 0000000123456780
0000ffff ffff0000 0000fffe00010000
fffe0002 00000003 00000002fffa0006
0000000a 0000000b 000000000000006e
00020000 00030000 0000000600000000
c0000000 00000004 0000000300000000
ffff8000 00018000 00017fff40000000
7fffffff 7fffffff 3fffffff00000001
